// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_axi_lite_bridge
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/axi_lite_bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_bridge_properties (
	input wire                                M_AXI_ACLK,
	input wire                                M_AXI_ARESETN,
	input wire bridge_pkg::axi_addr_t         m_axi_awaddr_i,
	input wire [bridge_pkg::PROT_W-1:0]       m_axi_awprot_i,
	input wire                                m_axi_awvalid_i,
	input wire                                m_axi_awready_i,
	input wire bridge_pkg::axi_data_t         m_axi_wdata_i,
	input wire [bridge_pkg::AXI_STRB_W-1:0]   m_axi_wstrb_i,
	input wire                                m_axi_wvalid_i,
	input wire                                m_axi_wready_i,
	input wire bridge_pkg::axi_addr_t         m_axi_araddr_i,
	input wire [bridge_pkg::PROT_W-1:0]       m_axi_arprot_i,
	input wire                                m_axi_arvalid_i,
	input wire                                m_axi_arready_i,
	input wire                                txn_done_i
);

	import bridge_pkg::*;

	// ------------------------------------------------------------------------
	// Valid and payload held until READY
	// ------------------------------------------------------------------------

	assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_awvalid_i && !m_axi_awready_i |=> m_axi_awvalid_i && $stable(m_axi_awaddr_i))
		else $error("AWVALID or AWADDR changed before AWREADY");

	assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_wvalid_i && !m_axi_wready_i |=> m_axi_wvalid_i && $stable(m_axi_wdata_i))
		else $error("WVALID or WDATA changed before WREADY");

	assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		m_axi_arvalid_i && !m_axi_arready_i |=> m_axi_arvalid_i && $stable(m_axi_araddr_i))
		else $error("ARVALID or ARADDR changed before ARREADY");

	// Fixed channel attributes
	assert property (@(posedge M_AXI_ACLK)
		m_axi_awprot_i == WR_PROT && m_axi_arprot_i == RD_PROT && m_axi_wstrb_i == WR_STRB)
		else $error("AWPROT, ARPROT or WSTRB off their fixed values");

	// One pulse per command
	assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		txn_done_i |=> !txn_done_i)
		else $error("txn_done_o high for two cycles");

endmodule

bind axi_lite_bridge axi_lite_bridge_properties u_props (
	.M_AXI_ACLK      (M_AXI_ACLK),
	.M_AXI_ARESETN   (M_AXI_ARESETN),
	.m_axi_awaddr_i  (m_axi_awaddr_o),
	.m_axi_awprot_i  (m_axi_awprot_o),
	.m_axi_awvalid_i (m_axi_awvalid_o),
	.m_axi_awready_i (m_axi_awready_i),
	.m_axi_wdata_i   (m_axi_wdata_o),
	.m_axi_wstrb_i   (m_axi_wstrb_o),
	.m_axi_wvalid_i  (m_axi_wvalid_o),
	.m_axi_wready_i  (m_axi_wready_i),
	.m_axi_araddr_i  (m_axi_araddr_o),
	.m_axi_arprot_i  (m_axi_arprot_o),
	.m_axi_arvalid_i (m_axi_arvalid_o),
	.m_axi_arready_i (m_axi_arready_i),
	.txn_done_i      (txn_done_o)
);

`default_nettype wire

// File: sim/tb_axi_lite_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_lite_bridge;

	import bridge_pkg::*;

	localparam int TIMEOUT = 200;
	localparam logic [31:0] SEED = 32'd39678;

	// CPU side drive and results
	logic      M_AXI_ACLK = 1'b0;
	logic      M_AXI_ARESETN;
	logic      init_txn;
	logic      rw;
	cpu_word_t cpu_addr;
	cpu_word_t cpu_wdata;
	logic      txn_done;
	logic      error;
	cpu_word_t cpu_r_addr;
	cpu_word_t cpu_r_data;

	// AXI master outputs
	axi_addr_t               awaddr;
	axi_addr_t               araddr;
	axi_data_t               wdata;
	logic [PROT_W-1:0]       awprot;
	logic [PROT_W-1:0]       arprot;
	logic [AXI_STRB_W-1:0]   wstrb;
	logic                    awvalid;
	logic                    wvalid;
	logic                    bready;
	logic                    arvalid;
	logic                    rready;

	// Slave model drive onto the DUT inputs
	// Readies sit high while the slave is idle
	logic      s_awready = 1'b1;
	logic      s_wready = 1'b1;
	logic      s_arready = 1'b1;
	logic      s_bvalid = 1'b0;
	logic      s_rvalid = 1'b0;
	axi_resp_e s_bresp = OKAY;
	axi_resp_e s_rresp = OKAY;
	axi_data_t s_rdata = '0;

	// Slave channel state owned by the slave process
	logic [1:0]            aw_cnt;
	logic [1:0]            w_cnt;
	logic [1:0]            ar_cnt;
	logic [1:0]            b_cnt;
	logic [1:0]            r_cnt;
	logic                  aw_got;
	logic                  w_got;
	logic                  b_pend;
	logic                  r_pend;
	axi_addr_t             aw_addr;
	axi_data_t             w_data;
	logic [AXI_STRB_W-1:0] w_strb;
	axi_data_t             merged;
	logic [31:0]           slave_rng = ~SEED;
	logic [31:0]           stim_rng = SEED;
	// Response state that reaches the bus 1 ns after each edge
	logic                  b_vld;
	logic                  r_vld;
	axi_resp_e             b_rsp;
	axi_resp_e             r_rsp;
	axi_data_t             r_dat;

	// Slave memory keyed by bus address
	// Reference model keyed by CPU address
	axi_data_t slave_mem [axi_addr_t];
	cpu_word_t ref_mem [cpu_word_t];

	always #2 M_AXI_ACLK = ~M_AXI_ACLK;

	axi_lite_bridge dut_i (
		.M_AXI_ACLK      (M_AXI_ACLK),
		.M_AXI_ARESETN   (M_AXI_ARESETN),
		.init_axi_txn_i  (init_txn),
		.rw_i            (rw),
		.cpu_rw_addr_i   (cpu_addr),
		.cpu_w_data_i    (cpu_wdata),
		.txn_done_o      (txn_done),
		.error_o         (error),
		.cpu_r_addr_o    (cpu_r_addr),
		.cpu_r_data_o    (cpu_r_data),
		.m_axi_awaddr_o  (awaddr),
		.m_axi_awprot_o  (awprot),
		.m_axi_awvalid_o (awvalid),
		.m_axi_awready_i (s_awready),
		.m_axi_wdata_o   (wdata),
		.m_axi_wstrb_o   (wstrb),
		.m_axi_wvalid_o  (wvalid),
		.m_axi_wready_i  (s_wready),
		.m_axi_bresp_i   (s_bresp),
		.m_axi_bvalid_i  (s_bvalid),
		.m_axi_bready_o  (bready),
		.m_axi_araddr_o  (araddr),
		.m_axi_arprot_o  (arprot),
		.m_axi_arvalid_o (arvalid),
		.m_axi_arready_i (s_arready),
		.m_axi_rdata_i   (s_rdata),
		.m_axi_rresp_i   (s_rresp),
		.m_axi_rvalid_i  (s_rvalid),
		.m_axi_rready_o  (rready)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Slave wait of 0 to 3 cycles
	function automatic logic [1:0] pick_delay();
		slave_rng = xorshift32(slave_rng);
		return slave_rng[1:0];
	endfunction

	// ------------------------------------------------------------------------
	// AXI4-Lite slave model
	// ------------------------------------------------------------------------

	always @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			aw_got = 1'b0;
			w_got = 1'b0;
			b_pend = 1'b0;
			r_pend = 1'b0;
			aw_cnt = 2'd0;
			w_cnt = 2'd0;
			ar_cnt = 2'd0;
			b_vld = 1'b0;
			r_vld = 1'b0;
			b_rsp = OKAY;
			r_rsp = OKAY;
			r_dat = '0;
		end
		else
		begin
			// B response dropped on its handshake
			if (b_vld && bready)
				b_vld = 1'b0;
			if (b_pend)
			begin
				if (b_cnt == 2'd0)
				begin
					b_vld = 1'b1;
					b_pend = 1'b0;
				end
				else
					b_cnt = b_cnt - 2'd1;
			end
			// Commit the write once address and data are both taken
			if (aw_got && w_got)
			begin
				aw_got = 1'b0;
				w_got = 1'b0;
				if (aw_addr[15])
					b_rsp = SLVERR;
				else
				begin
					b_rsp = OKAY;
					merged = slave_mem.exists(aw_addr) ? slave_mem[aw_addr] : '0;
					// Only strobed byte lanes change
					for (int i = 0; i < AXI_STRB_W; i++)
						if (w_strb[i])
							merged[8*i +: 8] = w_data[8*i +: 8];
					slave_mem[aw_addr] = merged;
				end
				b_cnt = pick_delay();
				b_pend = 1'b1;
			end
			// R channel
			if (r_vld && rready)
				r_vld = 1'b0;
			if (r_pend)
			begin
				if (r_cnt == 2'd0)
				begin
					r_vld = 1'b1;
					r_pend = 1'b0;
				end
				else
					r_cnt = r_cnt - 2'd1;
			end
			// AWREADY delay counts down only while AWVALID waits
			if (awvalid && s_awready)
			begin
				aw_addr = awaddr;
				aw_got = 1'b1;
				aw_cnt = pick_delay();
			end
			else if (awvalid && aw_cnt != 2'd0)
				aw_cnt = aw_cnt - 2'd1;
			// W channel
			if (wvalid && s_wready)
			begin
				w_data = wdata;
				w_strb = wstrb;
				w_got = 1'b1;
				w_cnt = pick_delay();
			end
			else if (wvalid && w_cnt != 2'd0)
				w_cnt = w_cnt - 2'd1;
			// Read data fixed at the AR handshake
			if (arvalid && s_arready)
			begin
				if (araddr[15])
				begin
					r_rsp = SLVERR;
					r_dat = '0;
				end
				else
				begin
					r_rsp = OKAY;
					r_dat = slave_mem.exists(araddr) ? slave_mem[araddr] : '0;
				end
				r_cnt = pick_delay();
				r_pend = 1'b1;
				ar_cnt = pick_delay();
			end
			else if (arvalid && ar_cnt != 2'd0)
				ar_cnt = ar_cnt - 2'd1;
		end
		#1;
		s_awready = (aw_cnt == 2'd0);
		s_wready = (w_cnt == 2'd0);
		s_arready = (ar_cnt == 2'd0);
		s_bvalid = b_vld;
		s_bresp = b_rsp;
		s_rvalid = r_vld;
		s_rresp = r_rsp;
		s_rdata = r_dat;
	end

	// ------------------------------------------------------------------------
	// Compare tasks and command driver
	// ------------------------------------------------------------------------

	task automatic check_word(input string what, input cpu_word_t got, input cpu_word_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	// Samples 1 ns after each edge where the registered results have settled
	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(posedge M_AXI_ACLK);
		#1;
		while (!txn_done && cycles < TIMEOUT)
		begin
			@(posedge M_AXI_ACLK);
			#1;
			cycles++;
		end
		if (!txn_done)
		begin
			$display("No txn_done_o pulse within %0d cycles at %0t ns", TIMEOUT, $time);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	endtask

	task automatic run_cmd(input logic write, input cpu_word_t addr, input cpu_word_t data);
		cpu_word_t exp_data;
		exp_data = '0;
		if (!write && !addr[15] && ref_mem.exists(addr))
			exp_data = ref_mem[addr];
		@(posedge M_AXI_ACLK);
		#1;
		rw = write;
		cpu_addr = addr;
		cpu_wdata = data;
		init_txn = 1'b1;
		wait_done();
		// Bit 15 selects the erroring region
		check_flag("error_o", error, addr[15]);
		if (!write)
		begin
			check_word("cpu_r_addr_o", cpu_r_addr, addr);
			check_word("cpu_r_data_o", cpu_r_data, exp_data);
		end
		else if (!addr[15])
			ref_mem[addr] = data;
		// Low level so the next command makes a new edge
		init_txn = 1'b0;
		repeat (2) @(posedge M_AXI_ACLK);
	endtask

	// Only the first edge of a long request level counts
	task automatic held_request(input cpu_word_t addr, input cpu_word_t data);
		int pulses;
		pulses = 0;
		@(posedge M_AXI_ACLK);
		#1;
		rw = 1'b1;
		cpu_addr = addr;
		cpu_wdata = data;
		init_txn = 1'b1;
		for (int n = 0; n < 40; n++)
		begin
			@(posedge M_AXI_ACLK);
			#1;
			if (txn_done)
				pulses++;
			if (n == 19)
				init_txn = 1'b0;
		end
		check_word("txn_done_o pulse count", cpu_word_t'(pulses), 16'd1);
		check_flag("error_o", error, 1'b0);
		ref_mem[addr] = data;
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial
	begin
		M_AXI_ARESETN = 1'b0;
		init_txn = 1'b0;
		rw = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		repeat (3) @(posedge M_AXI_ACLK);
		#1 M_AXI_ARESETN = 1'b1;
		// Idle results straight out of reset
		check_flag("txn_done_o after reset", txn_done, 1'b0);
		check_flag("error_o after reset", error, 1'b0);
		check_word("cpu_r_addr_o after reset", cpu_r_addr, 16'h0000);
		check_word("cpu_r_data_o after reset", cpu_r_data, 16'h0000);
		// Error region followed by recovery on a normal address
		run_cmd(1'b1, 16'h0008, 16'h1234);
		run_cmd(1'b1, 16'h8008, 16'hdead);
		// The erroring write leaves the stored word in place
		check_word("slave word at 0x0008",
			slave_mem.exists(32'h0000_0008) ? cpu_word_t'(slave_mem[32'h0000_0008]) : 16'h0000,
			ref_mem[16'h0008]);
		run_cmd(1'b0, 16'h8008, 16'h0000);
		run_cmd(1'b0, 16'h0008, 16'h0000);
		// Mixed traffic over 16 words plus the error region
		for (int n = 0; n < 300; n++)
		begin
			stim_rng = xorshift32(stim_rng);
			run_cmd(stim_rng[4], {stim_rng[10:8] == 3'd0, 11'd0, stim_rng[3:0]},
				stim_rng[31:16]);
		end
		held_request(16'h0010, 16'h5a5a);
		run_cmd(1'b0, 16'h0010, 16'h0000);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/axi_lite_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_bridge (
	input  wire                                 M_AXI_ACLK,
	input  wire                                 M_AXI_ARESETN,
	// CPU command side
	input  wire                                 init_axi_txn_i,
	input  wire                                 rw_i,
	input  wire bridge_pkg::cpu_word_t          cpu_rw_addr_i,
	input  wire bridge_pkg::cpu_word_t          cpu_w_data_i,
	output logic                                txn_done_o,
	output logic                                error_o,
	output bridge_pkg::cpu_word_t               cpu_r_addr_o,
	output bridge_pkg::cpu_word_t               cpu_r_data_o,
	// AW channel
	output bridge_pkg::axi_addr_t               m_axi_awaddr_o,
	output logic [bridge_pkg::PROT_W-1:0]       m_axi_awprot_o,
	output logic                                m_axi_awvalid_o,
	input  wire                                 m_axi_awready_i,
	// W channel
	output bridge_pkg::axi_data_t               m_axi_wdata_o,
	output logic [bridge_pkg::AXI_STRB_W-1:0]   m_axi_wstrb_o,
	output logic                                m_axi_wvalid_o,
	input  wire                                 m_axi_wready_i,
	// B channel
	input  wire [bridge_pkg::RESP_W-1:0]        m_axi_bresp_i,
	input  wire                                 m_axi_bvalid_i,
	output logic                                m_axi_bready_o,
	// AR channel
	output bridge_pkg::axi_addr_t               m_axi_araddr_o,
	output logic [bridge_pkg::PROT_W-1:0]       m_axi_arprot_o,
	output logic                                m_axi_arvalid_o,
	input  wire                                 m_axi_arready_i,
	// R channel
	input  wire bridge_pkg::axi_data_t          m_axi_rdata_i,
	input  wire [bridge_pkg::RESP_W-1:0]        m_axi_rresp_i,
	input  wire                                 m_axi_rvalid_i,
	output logic                                m_axi_rready_o
);

	import bridge_pkg::*;

	// Sequencer to engines
	logic      wr_start;
	logic      rd_start;
	axi_addr_t cmd_addr;
	axi_data_t cmd_wdata;
	// Engines back to sequencer
	logic      wr_done;
	logic      wr_err;
	logic      rd_done;
	logic      rd_err;
	cpu_word_t rd_data;

	// ------------------------------------------------------------------------
	// Command sequencer
	// ------------------------------------------------------------------------

	cmd_sequencer u_seq (
		.M_AXI_ACLK     (M_AXI_ACLK),
		.M_AXI_ARESETN  (M_AXI_ARESETN),
		.init_axi_txn_i (init_axi_txn_i),
		.rw_i           (rw_i),
		.cpu_rw_addr_i  (cpu_rw_addr_i),
		.cpu_w_data_i   (cpu_w_data_i),
		.wr_done_i      (wr_done),
		.wr_err_i       (wr_err),
		.rd_done_i      (rd_done),
		.rd_err_i       (rd_err),
		.rd_data_i      (rd_data),
		.wr_start_o     (wr_start),
		.rd_start_o     (rd_start),
		.addr_o         (cmd_addr),
		.wdata_o        (cmd_wdata),
		.txn_done_o     (txn_done_o),
		.error_o        (error_o),
		.cpu_r_addr_o   (cpu_r_addr_o),
		.cpu_r_data_o   (cpu_r_data_o)
	);

	// ------------------------------------------------------------------------
	// Channel engines, side by side
	// ------------------------------------------------------------------------

	// AW, W and B
	axi_write_engine u_wr (
		.M_AXI_ACLK      (M_AXI_ACLK),
		.M_AXI_ARESETN   (M_AXI_ARESETN),
		.start_i         (wr_start),
		.addr_i          (cmd_addr),
		.data_i          (cmd_wdata),
		.m_axi_awaddr_o  (m_axi_awaddr_o),
		.m_axi_awprot_o  (m_axi_awprot_o),
		.m_axi_awvalid_o (m_axi_awvalid_o),
		.m_axi_awready_i (m_axi_awready_i),
		.m_axi_wdata_o   (m_axi_wdata_o),
		.m_axi_wstrb_o   (m_axi_wstrb_o),
		.m_axi_wvalid_o  (m_axi_wvalid_o),
		.m_axi_wready_i  (m_axi_wready_i),
		.m_axi_bresp_i   (m_axi_bresp_i),
		.m_axi_bvalid_i  (m_axi_bvalid_i),
		.m_axi_bready_o  (m_axi_bready_o),
		.done_o          (wr_done),
		.err_o           (wr_err)
	);

	// AR and R
	axi_read_engine u_rd (
		.M_AXI_ACLK      (M_AXI_ACLK),
		.M_AXI_ARESETN   (M_AXI_ARESETN),
		.start_i         (rd_start),
		.addr_i          (cmd_addr),
		.m_axi_araddr_o  (m_axi_araddr_o),
		.m_axi_arprot_o  (m_axi_arprot_o),
		.m_axi_arvalid_o (m_axi_arvalid_o),
		.m_axi_arready_i (m_axi_arready_i),
		.m_axi_rdata_i   (m_axi_rdata_i),
		.m_axi_rresp_i   (m_axi_rresp_i),
		.m_axi_rvalid_i  (m_axi_rvalid_i),
		.m_axi_rready_o  (m_axi_rready_o),
		.done_o          (rd_done),
		.err_o           (rd_err),
		.data_o          (rd_data)
	);

endmodule

`default_nettype wire

// File: source/axi_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
	input  wire                           M_AXI_ACLK,
	input  wire                           M_AXI_ARESETN,
	// Launch from the sequencer
	input  wire                           start_i,
	input  wire bridge_pkg::axi_addr_t    addr_i,
	// AR channel
	output bridge_pkg::axi_addr_t         m_axi_araddr_o,
	output logic [bridge_pkg::PROT_W-1:0] m_axi_arprot_o,
	output logic                          m_axi_arvalid_o,
	input  wire                           m_axi_arready_i,
	// R channel
	input  wire bridge_pkg::axi_data_t    m_axi_rdata_i,
	input  wire [bridge_pkg::RESP_W-1:0]  m_axi_rresp_i,
	input  wire                           m_axi_rvalid_i,
	output logic                          m_axi_rready_o,
	// Completion
	output logic                          done_o,
	output logic                          err_o,
	output bridge_pkg::cpu_word_t         data_o
);

	import bridge_pkg::*;

	assign m_axi_arprot_o = RD_PROT;

	// Address held through back-pressure
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (start_i)
			m_axi_araddr_o <= addr_i;
	end

	// ------------------------------------------------------------------------
	// AR valid, one cycle after start until ARREADY
	// ------------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
			m_axi_arvalid_o <= 1'b0;
		else if (start_i)
			m_axi_arvalid_o <= 1'b1;
		else if (m_axi_arvalid_o && m_axi_arready_i)
			m_axi_arvalid_o <= 1'b0;
	end

	// ------------------------------------------------------------------------
	// R channel, one-cycle acknowledge after RVALID is seen
	// ------------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
			m_axi_rready_o <= 1'b0;
		else if (m_axi_rvalid_i && !m_axi_rready_o)
			m_axi_rready_o <= 1'b1;
		else
			m_axi_rready_o <= 1'b0;
	end

	// Result valid only in the handshake cycle
	assign done_o = m_axi_rready_o & m_axi_rvalid_i;
	assign err_o = done_o & m_axi_rresp_i[RESP_ERR_BIT];
	// Low lanes carry the CPU word
	assign data_o = m_axi_rdata_i[CPU_W-1:0];

endmodule

`default_nettype wire

// File: source/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine (
	input  wire                                 M_AXI_ACLK,
	input  wire                                 M_AXI_ARESETN,
	// Launch from the sequencer
	input  wire                                 start_i,
	input  wire bridge_pkg::axi_addr_t          addr_i,
	input  wire bridge_pkg::axi_data_t          data_i,
	// AW channel
	output bridge_pkg::axi_addr_t               m_axi_awaddr_o,
	output logic [bridge_pkg::PROT_W-1:0]       m_axi_awprot_o,
	output logic                                m_axi_awvalid_o,
	input  wire                                 m_axi_awready_i,
	// W channel
	output bridge_pkg::axi_data_t               m_axi_wdata_o,
	output logic [bridge_pkg::AXI_STRB_W-1:0]   m_axi_wstrb_o,
	output logic                                m_axi_wvalid_o,
	input  wire                                 m_axi_wready_i,
	// B channel
	input  wire [bridge_pkg::RESP_W-1:0]        m_axi_bresp_i,
	input  wire                                 m_axi_bvalid_i,
	output logic                                m_axi_bready_o,
	// Completion
	output logic                                done_o,
	output logic                                err_o
);

	import bridge_pkg::*;

	// Constant channel attributes
	assign m_axi_awprot_o = WR_PROT;
	assign m_axi_wstrb_o = WR_STRB;

	// Payload held through back-pressure
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (start_i)
		begin
			m_axi_awaddr_o <= addr_i;
			m_axi_wdata_o <= data_i;
		end
	end

	// ------------------------------------------------------------------------
	// AW and W valid, raised together, dropped on their own READY
	// ------------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			m_axi_awvalid_o <= 1'b0;
			m_axi_wvalid_o <= 1'b0;
		end
		else if (start_i)
		begin
			m_axi_awvalid_o <= 1'b1;
			m_axi_wvalid_o <= 1'b1;
		end
		else
		begin
			if (m_axi_awvalid_o && m_axi_awready_i)
				m_axi_awvalid_o <= 1'b0;
			if (m_axi_wvalid_o && m_axi_wready_i)
				m_axi_wvalid_o <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// B channel, one-cycle acknowledge after BVALID is seen
	// ------------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
			m_axi_bready_o <= 1'b0;
		else if (m_axi_bvalid_i && !m_axi_bready_o)
			m_axi_bready_o <= 1'b1;
		else
			m_axi_bready_o <= 1'b0;
	end

	// Handshake cycle is the completion
	assign done_o = m_axi_bready_o & m_axi_bvalid_i;
	assign err_o = done_o & m_axi_bresp_i[RESP_ERR_BIT];

endmodule

`default_nettype wire

// File: source/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

	// ------------------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------------------

	// AXI4-Lite side
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	// One strobe bit per byte lane
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// CPU side, address and data share one width
	localparam int CPU_W = 16;

	// Response and protection fields
	localparam int RESP_W = 2;
	localparam int PROT_W = 3;

	// ------------------------------------------------------------------------
	// Fixed bus values
	// ------------------------------------------------------------------------

	// Unprivileged, secure, data access
	localparam logic [PROT_W-1:0] WR_PROT = 3'b000;
	// Privileged access
	localparam logic [PROT_W-1:0] RD_PROT = 3'b001;
	// Only the two low byte lanes carry CPU data
	localparam logic [AXI_STRB_W-1:0] WR_STRB = 4'b0011;
	// SLVERR and DECERR both have this bit set
	localparam int RESP_ERR_BIT = 1;

	// ------------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------------

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [CPU_W-1:0] cpu_word_t;

	// AXI response encoding
	typedef enum logic [RESP_W-1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// Command sequencer states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'b00,
		ST_WRITE = 2'b01,
		ST_READ  = 2'b10
	} seq_state_e;

endpackage

`default_nettype wire

// File: source/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
	input  wire                        M_AXI_ACLK,
	input  wire                        M_AXI_ARESETN,
	// CPU command port
	input  wire                        init_axi_txn_i,
	input  wire                        rw_i,
	input  wire bridge_pkg::cpu_word_t cpu_rw_addr_i,
	input  wire bridge_pkg::cpu_word_t cpu_w_data_i,
	// Engine completions
	input  wire                        wr_done_i,
	input  wire                        wr_err_i,
	input  wire                        rd_done_i,
	input  wire                        rd_err_i,
	input  wire bridge_pkg::cpu_word_t rd_data_i,
	// Engine launch
	output logic                       wr_start_o,
	output logic                       rd_start_o,
	output bridge_pkg::axi_addr_t      addr_o,
	output bridge_pkg::axi_data_t      wdata_o,
	// CPU results
	output logic                       txn_done_o,
	output logic                       error_o,
	output bridge_pkg::cpu_word_t      cpu_r_addr_o,
	output bridge_pkg::cpu_word_t      cpu_r_data_o
);

	import bridge_pkg::*;

	// Two-flop view of the start request
	logic       init_ff_q;
	logic       init_ff2_q;
	// High for one cycle after a 0-to-1 transition
	logic       start_edge;
	// Edge accepted only while idle
	logic       accept;
	seq_state_e state_q;

	assign start_edge = init_ff_q & ~init_ff2_q;
	assign accept = start_edge && (state_q == ST_IDLE);

	// ------------------------------------------------------------------------
	// Start request synchronizer
	// ------------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			init_ff_q <= 1'b0;
			init_ff2_q <= 1'b0;
		end
		else
		begin
			init_ff_q <= init_axi_txn_i;
			init_ff2_q <= init_ff_q;
		end
	end

	// Command capture, zero-extended onto the bus width
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (accept)
		begin
			addr_o <= {{(AXI_ADDR_W-CPU_W){1'b0}}, cpu_rw_addr_i};
			wdata_o <= {{(AXI_DATA_W-CPU_W){1'b0}}, cpu_w_data_i};
		end
	end

	// ------------------------------------------------------------------------
	// Command FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			state_q <= ST_IDLE;
			wr_start_o <= 1'b0;
			rd_start_o <= 1'b0;
			txn_done_o <= 1'b0;
			error_o <= 1'b0;
			cpu_r_addr_o <= '0;
			cpu_r_data_o <= '0;
		end
		else
		begin
			// Launch and done are single-cycle pulses
			wr_start_o <= 1'b0;
			rd_start_o <= 1'b0;
			txn_done_o <= 1'b0;
			case (state_q)
				ST_IDLE:
				begin
					if (accept)
					begin
						// Error flag of the previous command ends here
						error_o <= 1'b0;
						if (rw_i)
						begin
							wr_start_o <= 1'b1;
							state_q <= ST_WRITE;
						end
						else
						begin
							rd_start_o <= 1'b1;
							state_q <= ST_READ;
						end
					end
				end
				ST_WRITE:
				begin
					// B handshake seen, report one cycle later
					if (wr_done_i)
					begin
						txn_done_o <= 1'b1;
						error_o <= wr_err_i;
						state_q <= ST_IDLE;
					end
				end
				ST_READ:
				begin
					// Result registers load even on an error response
					if (rd_done_i)
					begin
						txn_done_o <= 1'b1;
						error_o <= rd_err_i;
						cpu_r_addr_o <= addr_o[CPU_W-1:0];
						cpu_r_data_o <= rd_data_i;
						state_q <= ST_IDLE;
					end
				end
				default:
				begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tb.f
source/bridge_pkg.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/cmd_sequencer.sv
source/axi_lite_bridge.sv
sim/axi_lite_bridge_properties.sv
sim/tb_axi_lite_bridge.sv
